// File: hw/axis_beat_pkg.sv
`default_nettype none

package axis_beat_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int USER_WIDTH = 2;

    // One AXI-Stream beat as seen by sources and sinks
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic [STRB_WIDTH-1:0] keep;
        logic                  last;
        logic [USER_WIDTH-1:0] user;
    } stream_beat_t;

    // Serializer side beat, stream id carried as tid
    typedef struct packed {
        stream_beat_t beat;
        logic [1:0]   tid;
    } tagged_beat_t;

endpackage

`default_nettype wire

// File: hw/axis_sw_top.sv
`timescale 1ns/1ns
`default_nettype none

module axis_sw_top
    import axis_beat_pkg::*;
    import switch_route_pkg::*;
#(
    parameter int FIFO_DEPTH      = DEFAULT_FIFO_DEPTH,
    parameter int READY_THRESHOLD = DEFAULT_READY_THRESHOLD
) (
    input  wire logic         axis_clk,
    input  wire logic         axi_reset_n,

    // User project source
    input  wire stream_beat_t up_as,
    input  wire logic         up_as_tvalid,
    output logic              as_up_tready,
    // Register bridge source
    input  wire stream_beat_t aa_as,
    input  wire logic         aa_as_tvalid,
    output logic              as_aa_tready,
    // Logic analyzer source
    input  wire stream_beat_t la_as,
    input  wire logic         la_as_tvalid,
    output logic              as_la_tready,

    // Toward the serializer
    output tagged_beat_t      as_is_beat,
    output logic              as_is_tvalid,
    input  wire logic         is_as_tready,

    // From the serializer
    input  wire tagged_beat_t is_as_beat,
    input  wire logic         is_as_tvalid,
    output logic              as_is_tready,

    // Return sinks
    output stream_beat_t      as_up_beat,
    output logic              as_up_tvalid,
    input  wire logic         up_as_tready,
    output stream_beat_t      as_aa_beat,
    output logic              as_aa_tvalid,
    input  wire logic         aa_as_tready
);

    grant_t grant;
    logic   frame_done;

    rr_arbiter u_arbiter (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .req         ({la_as_tvalid, aa_as_tvalid, up_as_tvalid}),
        .frame_done  (frame_done),
        .grant       (grant)
    );

    upstream_mux u_mux (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .grant        (grant),
        .src_beat     ({la_as, aa_as, up_as}),
        .src_valid    ({la_as_tvalid, aa_as_tvalid, up_as_tvalid}),
        .is_as_tready (is_as_tready),
        .src_ready    ({as_la_tready, as_aa_tready, as_up_tready}),
        .as_is_beat   (as_is_beat),
        .as_is_tvalid (as_is_tvalid),
        .frame_done   (frame_done)
    );

    downstream_router #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .READY_THRESHOLD (READY_THRESHOLD)
    ) u_router (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .is_as_beat   (is_as_beat),
        .is_as_tvalid (is_as_tvalid),
        .up_as_tready (up_as_tready),
        .aa_as_tready (aa_as_tready),
        .as_is_tready (as_is_tready),
        .as_up_beat   (as_up_beat),
        .as_up_tvalid (as_up_tvalid),
        .as_aa_beat   (as_aa_beat),
        .as_aa_tvalid (as_aa_tvalid)
    );

endmodule

`default_nettype wire

// File: hw/beat_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module beat_fifo
    import axis_beat_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                        axis_clk,
    input  wire logic                        axi_reset_n,
    input  wire logic                        wr_en,
    input  wire tagged_beat_t                wr_beat,
    input  wire logic                        rd_en,
    output tagged_beat_t                     rd_beat,
    output logic                             empty,
    output logic [$clog2(FIFO_DEPTH):0]      level
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    tagged_beat_t          mem [FIFO_DEPTH];

    // Top bit flags a wrap, so full and empty differ
    logic [ADDR_WIDTH:0]   wr_ptr;
    logic [ADDR_WIDTH:0]   rd_ptr;

    ////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat;
        end
    end

    // Head is visible without a read cycle
    assign rd_beat = mem[rd_ptr[ADDR_WIDTH-1:0]];

    assign empty = (wr_ptr == rd_ptr);
    assign level = wr_ptr - rd_ptr;

endmodule

`default_nettype wire

// File: hw/downstream_router.sv
`timescale 1ns/1ns
`default_nettype none

module downstream_router
    import axis_beat_pkg::*;
    import switch_route_pkg::*;
#(
    parameter int FIFO_DEPTH      = 16,
    parameter int READY_THRESHOLD = 6
) (
    input  wire logic         axis_clk,
    input  wire logic         axi_reset_n,
    input  wire tagged_beat_t is_as_beat,
    input  wire logic         is_as_tvalid,
    input  wire logic         up_as_tready,
    input  wire logic         aa_as_tready,
    output logic              as_is_tready,
    output stream_beat_t      as_up_beat,
    output logic              as_up_tvalid,
    output stream_beat_t      as_aa_beat,
    output logic              as_aa_tvalid
);

    tagged_beat_t                 head;
    logic                         empty;
    logic [$clog2(FIFO_DEPTH):0]  level;
    logic                         wr_en;
    logic                         rd_en;
    logic                         pop;

    // Headroom above the threshold absorbs beats already in flight
    assign as_is_tready = (level <= READY_THRESHOLD);
    assign wr_en        = is_as_tvalid & as_is_tready;

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .wr_en       (wr_en),
        .wr_beat     (is_as_beat),
        .rd_en       (rd_en),
        .rd_beat     (head),
        .empty       (empty),
        .level       (level)
    );

    ////////////////////////////////////////
    // Head decode by stream id
    ////////////////////////////////////////

    always_comb begin
        as_up_tvalid = 1'b0;
        as_aa_tvalid = 1'b0;
        case (head.tid)
            ID_USER: begin
                as_up_tvalid = !empty;
                pop          = up_as_tready;
            end
            ID_BRIDGE: begin
                as_aa_tvalid = !empty;
                pop          = aa_as_tready;
            end
            // No sink for these ids, drop one per cycle
            default: pop = 1'b1;
        endcase
    end

    assign rd_en = !empty & pop;

    assign as_up_beat = head.beat;
    assign as_aa_beat = head.beat;

endmodule

`default_nettype wire

// File: hw/rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter
    import switch_route_pkg::*;
(
    input  wire logic   axis_clk,
    input  wire logic   axi_reset_n,
    input  wire grant_t req,
    input  wire logic   frame_done,
    output grant_t      grant
);

    stream_id_t base_q;
    grant_t     pick;

    // Source id at a given offset from the base, modulo the source count
    function automatic int unsigned rr_index(stream_id_t base, int unsigned offset);
        int unsigned sum;
        sum = int'(base) + offset;
        if (sum >= NUM_SOURCES) begin
            sum = sum - NUM_SOURCES;
        end
        return sum;
    endfunction

    ////////////////////////////////////////
    // Priority search from the base
    ////////////////////////////////////////

    // Walk from the farthest offset back, so the nearest requester wins
    always_comb begin
        pick = '0;
        for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
            if (req[rr_index(base_q, i)]) begin
                pick = grant_t'(1) << rr_index(base_q, i);
            end
        end
    end

    ////////////////////////////////////////
    // Grant lock and base rotation
    ////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            grant  <= '0;
            base_q <= ID_USER;
        end else if (grant == '0) begin
            grant <= pick;
        end else if (frame_done) begin
            // Idle for one cycle, next search starts after the finished source
            grant  <= '0;
            base_q <= stream_id_t'(rr_index(grant_to_id(grant), 1));
        end
    end

endmodule

`default_nettype wire

// File: hw/switch_route_pkg.sv
`default_nettype none

package switch_route_pkg;

    localparam int NUM_SOURCES = 3;

    // Upstream source ids, also used as return stream ids
    typedef enum logic [1:0] {
        ID_USER     = 2'd0,
        ID_BRIDGE   = 2'd1,
        ID_ANALYZER = 2'd2
    } stream_id_t;

    // One bit per source
    typedef logic [NUM_SOURCES-1:0] grant_t;

    localparam int DEFAULT_FIFO_DEPTH      = 16;
    localparam int DEFAULT_READY_THRESHOLD = 6;

    // Index of the set bit of a one-hot grant
    function automatic stream_id_t grant_to_id(grant_t g);
        stream_id_t id;
        id = ID_USER;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            if (g[i]) begin
                id = stream_id_t'(i);
            end
        end
        return id;
    endfunction

endpackage

`default_nettype wire

// File: hw/upstream_mux.sv
`timescale 1ns/1ns
`default_nettype none

module upstream_mux
    import axis_beat_pkg::*;
    import switch_route_pkg::*;
(
    input  wire logic                           axis_clk,
    input  wire logic                           axi_reset_n,
    input  wire grant_t                         grant,
    input  wire stream_beat_t [NUM_SOURCES-1:0] src_beat,
    input  wire logic [NUM_SOURCES-1:0]         src_valid,
    input  wire logic                           is_as_tready,
    output logic [NUM_SOURCES-1:0]              src_ready,
    output tagged_beat_t                        as_is_beat,
    output logic                                as_is_tvalid,
    output logic                                frame_done
);

    stream_id_t   sel_id;
    stream_beat_t sel_beat;
    logic         accept;

    ////////////////////////////////////////
    // Source select
    ////////////////////////////////////////

    assign sel_id   = grant_to_id(grant);
    assign sel_beat = src_beat[sel_id];

    // Register is empty or drains this cycle whenever the serializer is ready
    assign src_ready = grant & {NUM_SOURCES{is_as_tready}};

    assign accept     = |(src_ready & src_valid);
    assign frame_done = accept & sel_beat.last;

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            as_is_tvalid <= 1'b0;
        end else if (accept) begin
            as_is_tvalid <= 1'b1;
        end else if (is_as_tready) begin
            as_is_tvalid <= 1'b0;
        end
    end

    // Holds while the serializer stalls
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            as_is_beat.beat <= sel_beat;
            as_is_beat.tid  <= sel_id;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
hw/axis_beat_pkg.sv
hw/switch_route_pkg.sv
hw/rr_arbiter.sv
hw/upstream_mux.sv
hw/beat_fifo.sv
hw/downstream_router.sv
hw/axis_sw_top.sv
verification/axis_sw_properties.sv
verification/axis_sw_tb.sv

// File: verification/axis_sw_golden.txt
// Digits: kind, id, user, last, strb, keep, then 8 data digits
// Kind F section (user digit is mode), 1 source, 2 serializer, 3 return, 4 sink, E end
// Analyzer frame after reset
F0000000000000
1210FFA0000001 2210FFA0000001
1211F7A0000002 2211F7A0000002
// Three sources at once, order 0 1 2
F0000000000000
1001FFB0000000 1121FFB1000000 123133B2000000
2001FFB0000000 2121FFB1000000 223133B2000000
// Repeat after a frame from 2
F0000000000000
1001FFC0000000 1121FFC1000000 123133C2000000
2001FFC0000000 2121FFC1000000 223133C2000000
// Single frame from 0
F0000000000000
1001FFD0000000 2001FFD0000000
// Round after 0, order 1 2 0
F0000000000000
1001FFE0000000 1101FFE1000000 1201FFE2000000
2101FFE1000000 2201FFE2000000 2001FFE0000000
// Random serializer ready
F0100000000000
1010FF60000001 1011FF60000002
1130FF61000001 1131F061000002
1221FF62000001
2130FF61000001 2131F061000002 2221FF62000001
2010FF60000001 2011FF60000002
// Return routing, ids 2 and 3 dropped
F0000000000000
3001FF70000001 3201FF72000001 3111FF71000001
3321FF73000001 3030F070000002
4001FF70000001 4111FF71000001 4030F070000002
// Sinks held until the return path fills
F0200000000000
3001FF80000001 4001FF80000001
3101FF80000002 4101FF80000002
3001FF80000003 4001FF80000003
3101FF80000004 4101FF80000004
3001FF80000005 4001FF80000005
3101FF80000006 4101FF80000006
3001FF80000007 4001FF80000007
3101FF80000008 4101FF80000008
E0000000000000

// File: verification/axis_sw_properties.sv
`timescale 1ns/1ns
`default_nettype none

module axis_sw_properties
    import axis_beat_pkg::*;
(
    input wire logic         axis_clk,
    input wire logic         axi_reset_n,
    input wire logic         as_up_tready,
    input wire logic         as_aa_tready,
    input wire logic         as_la_tready,
    input wire tagged_beat_t as_is_beat,
    input wire logic         as_is_tvalid,
    input wire logic         is_as_tready,
    input wire logic         as_up_tvalid,
    input wire logic         as_aa_tvalid
);

    one_source_ready: assert property (
        @(posedge axis_clk) disable iff (!axi_reset_n)
        $onehot0({as_la_tready, as_aa_tready, as_up_tready})
    ) else $error("More than one source ready");

    // Serializer stall holds the output register
    serializer_hold: assert property (
        @(posedge axis_clk) disable iff (!axi_reset_n)
        as_is_tvalid && !is_as_tready |=> as_is_tvalid && $stable(as_is_beat)
    ) else $error("as_is beat changed while stalled");

    one_sink_valid: assert property (
        @(posedge axis_clk) disable iff (!axi_reset_n)
        !(as_up_tvalid && as_aa_tvalid)
    ) else $error("Both return sinks valid");

endmodule

bind axis_sw_top axis_sw_properties u_props (
    .axis_clk     (axis_clk),
    .axi_reset_n  (axi_reset_n),
    .as_up_tready (as_up_tready),
    .as_aa_tready (as_aa_tready),
    .as_la_tready (as_la_tready),
    .as_is_beat   (as_is_beat),
    .as_is_tvalid (as_is_tvalid),
    .is_as_tready (is_as_tready),
    .as_up_tvalid (as_up_tvalid),
    .as_aa_tvalid (as_aa_tvalid)
);

`default_nettype wire

// File: verification/axis_sw_tb.sv
`timescale 1ns/1ns
`default_nettype none

module axis_sw_tb
    import axis_beat_pkg::*;
    import switch_route_pkg::*;
();

    localparam int THRESHOLD       = DEFAULT_READY_THRESHOLD;
    localparam int GOLDEN_SIZE     = 128;
    localparam int SECTION_TIMEOUT = 1000;

    logic                   axis_clk;
    logic                   axi_reset_n;
    stream_beat_t           src_beat [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] src_valid;
    logic [NUM_SOURCES-1:0] src_ready;
    tagged_beat_t           as_is_beat;
    logic                   as_is_tvalid;
    logic                   is_as_tready;
    tagged_beat_t           is_as_beat;
    logic                   is_as_tvalid;
    logic                   as_is_tready;
    stream_beat_t           as_up_beat;
    logic                   as_up_tvalid;
    logic                   up_as_tready;
    stream_beat_t           as_aa_beat;
    logic                   as_aa_tvalid;
    logic                   aa_as_tready;

    // Golden record fields kind, id, user, last, strb, keep and data
    logic [55:0]            golden [GOLDEN_SIZE];
    int                     gp;
    stream_beat_t           src_q [NUM_SOURCES][$];
    int                     src_idx [NUM_SOURCES];
    tagged_beat_t           ser_q [$];
    tagged_beat_t           ret_q [$];
    int                     ret_idx;
    stream_beat_t           up_q [$];
    stream_beat_t           aa_q [$];
    int                     mode;
    logic                   sinks_held;

    axis_sw_top dut0 (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .up_as        (src_beat[0]),
        .up_as_tvalid (src_valid[0]),
        .as_up_tready (src_ready[0]),
        .aa_as        (src_beat[1]),
        .aa_as_tvalid (src_valid[1]),
        .as_aa_tready (src_ready[1]),
        .la_as        (src_beat[2]),
        .la_as_tvalid (src_valid[2]),
        .as_la_tready (src_ready[2]),
        .as_is_beat   (as_is_beat),
        .as_is_tvalid (as_is_tvalid),
        .is_as_tready (is_as_tready),
        .is_as_beat   (is_as_beat),
        .is_as_tvalid (is_as_tvalid),
        .as_is_tready (as_is_tready),
        .as_up_beat   (as_up_beat),
        .as_up_tvalid (as_up_tvalid),
        .up_as_tready (up_as_tready),
        .as_aa_beat   (as_aa_beat),
        .as_aa_tvalid (as_aa_tvalid),
        .aa_as_tready (aa_as_tready)
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    function automatic stream_beat_t to_beat(logic [55:0] rec);
        stream_beat_t b;
        b.data = rec[31:0];
        b.keep = rec[35:32];
        b.strb = rec[39:36];
        b.last = rec[40];
        b.user = rec[45:44];
        return b;
    endfunction

    function automatic tagged_beat_t to_tagged(logic [55:0] rec);
        tagged_beat_t t;
        t.beat = to_beat(rec);
        t.tid  = rec[49:48];
        return t;
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error: time %0t, %s expected %h, got %h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////
    // Golden sections
    ////////////////////////////////////////

    task automatic load_section(output bit found);
        logic [55:0] rec;
        found = 1'b0;
        for (int s = 0; s < NUM_SOURCES; s++) begin
            src_q[s].delete();
            src_idx[s] = 0;
        end
        ser_q.delete();
        ret_q.delete();
        up_q.delete();
        aa_q.delete();
        ret_idx = 0;
        rec = golden[gp];
        assert (!$isunknown(rec)) else begin
            $display("The golden file ends without an end record");
            stop_on_error();
        end
        if (rec[55:52] == 4'hF) begin
            found = 1'b1;
            mode  = rec[45:44];
            gp++;
            while (gp < GOLDEN_SIZE && golden[gp][55:52] inside {4'h1, 4'h2, 4'h3, 4'h4}) begin
                rec = golden[gp];
                case (rec[55:52])
                    4'h1: src_q[rec[49:48]].push_back(to_beat(rec));
                    4'h2: ser_q.push_back(to_tagged(rec));
                    4'h3: ret_q.push_back(to_tagged(rec));
                    default: begin
                        if (rec[48]) aa_q.push_back(to_beat(rec));
                        else up_q.push_back(to_beat(rec));
                    end
                endcase
                gp++;
            end
        end
    endtask

    function automatic bit section_done();
        bit done;
        done = (ser_q.size() == 0) && (up_q.size() == 0) && (aa_q.size() == 0);
        done = done && (ret_idx == ret_q.size());
        for (int s = 0; s < NUM_SOURCES; s++) begin
            done = done && (src_idx[s] == src_q[s].size());
        end
        return done;
    endfunction

    ////////////////////////////////////////
    // Per-cycle monitor and driver
    ////////////////////////////////////////

    task automatic sample_outputs();
        for (int s = 0; s < NUM_SOURCES; s++) begin
            if (src_valid[s] && src_ready[s]) src_idx[s]++;
        end
        if (as_is_tvalid && is_as_tready) begin
            assert (ser_q.size() > 0) else begin
                $display("Beat on as_is_beat with none expected at time %0t", $time);
                stop_on_error();
            end
            check_value("as_is_beat", as_is_beat, ser_q.pop_front());
        end
        if (is_as_tvalid && as_is_tready) begin
            ret_idx++;
        end
        if (as_up_tvalid && up_as_tready) begin
            assert (up_q.size() > 0) else begin
                $display("Beat on as_up_beat with none expected at time %0t", $time);
                stop_on_error();
            end
            check_value("as_up_beat", as_up_beat, up_q.pop_front());
        end
        if (as_aa_tvalid && aa_as_tready) begin
            assert (aa_q.size() > 0) else begin
                $display("Beat on as_aa_beat with none expected at time %0t", $time);
                stop_on_error();
            end
            check_value("as_aa_beat", as_aa_beat, aa_q.pop_front());
        end
    endtask

    task automatic drive_inputs();
        for (int s = 0; s < NUM_SOURCES; s++) begin
            src_valid[s] = (src_idx[s] < src_q[s].size());
            if (src_valid[s]) src_beat[s] = src_q[s][src_idx[s]];
        end
        is_as_tready = (mode == 1) ? 1'($urandom % 2) : 1'b1;
        is_as_tvalid = (ret_idx < ret_q.size());
        if (is_as_tvalid) is_as_beat = ret_q[ret_idx];
        // Queue full enough that the return path stops accepting
        if (mode == 2 && sinks_held && !as_is_tready) begin
            check_value("accepted return beats", ret_idx, THRESHOLD + 1);
            sinks_held = 1'b0;
        end
        up_as_tready = !sinks_held && (mode != 1 || 1'($urandom % 2));
        aa_as_tready = !sinks_held && (mode != 1 || 1'($urandom % 2));
    endtask

    task automatic run_cycle();
        @(posedge axis_clk);
        sample_outputs();
        @(negedge axis_clk);
        drive_inputs();
    endtask

    task automatic run_section(int section);
        int cycles;
        cycles     = 0;
        sinks_held = (mode == 2);
        drive_inputs();
        while (!section_done()) begin
            run_cycle();
            cycles++;
            if (cycles > SECTION_TIMEOUT) begin
                $display("Timeout: section %0d did not complete", section);
                stop_on_error();
            end
        end
        // Idle cycles catch stray beats
        repeat (4) run_cycle();
    endtask

    initial begin
        bit found;
        int section;
        void'($urandom(32'h19d51a9d));
        axi_reset_n  = 1'b0;
        src_valid    = '0;
        is_as_tready = 1'b1;
        is_as_tvalid = 1'b0;
        is_as_beat   = '0;
        up_as_tready = 1'b0;
        aa_as_tready = 1'b0;
        mode         = 0;
        sinks_held   = 1'b0;
        gp           = 0;
        ret_idx      = 0;
        for (int s = 0; s < NUM_SOURCES; s++) begin
            src_beat[s] = '0;
            src_idx[s]  = 0;
        end
        $readmemh("verification/axis_sw_golden.txt", golden);
        repeat (5) @(posedge axis_clk);
        @(negedge axis_clk);
        axi_reset_n = 1'b1;

        check_value("as_is_tvalid", as_is_tvalid, 0);
        check_value("as_up_tvalid", as_up_tvalid, 0);
        check_value("as_aa_tvalid", as_aa_tvalid, 0);
        check_value("source tready", src_ready, 0);
        check_value("grant", dut0.u_arbiter.grant, 0);
        check_value("as_is_tready", as_is_tready, 1);

        section = 0;
        found   = 1'b1;
        while (found) begin
            load_section(found);
            if (found) begin
                section++;
                run_section(section);
            end
        end

        if (section > 0 && golden[gp][55:52] == 4'hE) begin
            $display("No errors");
            $finish;
        end else begin
            $display("The golden file holds a malformed record at entry %0d", gp);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire
